// File: verilog/rw_mgr_pkg.sv
// shared widths, vector types, host command codes, instruction field
// positions and the sequencer state encoding for the read/write manager
package rw_mgr_pkg;

	localparam int AC_BUS_WIDTH = 24;
	localparam int AC_CS_LSB = 24;
	localparam int CMD_ADDR_WIDTH = 12;
	localparam int HOST_DATA_WIDTH = 32;
	localparam int CMD_CODE_LSB = 8;

	typedef logic [19:0] inst_word_t;
	typedef logic [6:0] pc_t;
	typedef logic [5:0] ac_addr_t;
	typedef logic [31:0] ac_word_t;
	typedef logic [CMD_ADDR_WIDTH-1:0] cmd_addr_t;
	typedef logic [HOST_DATA_WIDTH-1:0] host_data_t;
	typedef logic [3:0] cmd_code_t;
	typedef logic [7:0] loop_cnt_t;
	typedef logic [3:0] do_code_t;
	typedef logic [2:0] dm_code_t;

	localparam cmd_code_t CMD_RUN = 4'd0;
	localparam cmd_code_t CMD_LOAD_CNTR = 4'd2;
	localparam cmd_code_t CMD_LOAD_JUMP = 4'd3;
	localparam cmd_code_t CMD_CLEAR_ERR = 4'd4;
	localparam cmd_code_t CMD_SET_CS_MASK = 4'd5;
	localparam cmd_code_t CMD_WRITE_INST = 4'd6;
	localparam cmd_code_t CMD_WRITE_AC = 4'd7;
	localparam cmd_code_t CMD_SOFT_RESET = 4'd8;

	// bits 17 and 16 are reserved
	localparam int INST_RETURN_BIT = 19;
	localparam int INST_READ_BIT = 18;
	localparam int INST_JUMP_BIT = 15;
	localparam int INST_JREG_MSB = 14;
	localparam int INST_JREG_LSB = 13;
	localparam int INST_AC_MSB = 12;
	localparam int INST_AC_LSB = 7;
	localparam int INST_DO_MSB = 6;
	localparam int INST_DO_LSB = 3;
	localparam int INST_DM_MSB = 2;
	localparam int INST_DM_LSB = 0;

	typedef enum logic [1:0] {
		RW_IDLE,
		RW_RUNNING,
		RW_READING,
		RW_DONE
	} rw_state_e;

	// one mask bit per byte lane of a beat
	function automatic int dm_per_beat(input int dq_width);
		return (dq_width + 7) / 8;
	endfunction

endpackage

// File: verilog/rw_cmd_decoder.sv
// host command register stage: captures strobes, address and data,
// turns a new write into one strobe per command code and keeps the
// chip-select mask and the soft reset pulse
module rw_cmd_decoder import rw_mgr_pkg::*; #(
	parameter int MEM_CS_WIDTH = 2
) (
	input  logic afi_clk,
	input  logic afi_reset_n,
	input  logic cmd_write_i,
	input  logic cmd_read_i,
	input  cmd_addr_t avl_address_i,
	input  host_data_t avl_writedata_i,
	output cmd_addr_t cmd_addr_o,
	output host_data_t cmd_data_o,
	output logic write_pending_o,
	output logic read_pending_o,
	output logic run_o,
	output logic load_o,
	output logic load_cntr_o,
	output logic load_jump_o,
	output logic clear_err_o,
	output logic write_inst_o,
	output logic write_ac_o,
	output logic [MEM_CS_WIDTH-1:0] cs_mask_o,
	output logic soft_reset_o
);

	logic write_q;
	logic write_d;
	logic read_q;
	logic new_write;
	cmd_code_t code;

	always_ff @(posedge afi_clk or negedge afi_reset_n) begin
		if (!afi_reset_n) begin
			write_q <= 1'b0;
			write_d <= 1'b0;
			read_q <= 1'b0;
			cs_mask_o <= '0;
			soft_reset_o <= 1'b0;
		end else begin
			write_q <= cmd_write_i;
			write_d <= write_q;
			read_q <= cmd_read_i;
			if (new_write && code == CMD_SET_CS_MASK)
				cs_mask_o <= cmd_data_o[MEM_CS_WIDTH-1:0];
			soft_reset_o <= new_write && code == CMD_SOFT_RESET;
		end
	end

	always_ff @(posedge afi_clk) begin
		cmd_addr_o <= avl_address_i;
		cmd_data_o <= avl_writedata_i;
	end

	// the host holds its strobe, so only the first registered cycle counts
	assign new_write = write_q & ~write_d;
	assign code = cmd_addr_o[CMD_CODE_LSB +: $bits(cmd_code_t)];

	assign write_pending_o = write_q;
	assign read_pending_o = read_q;
	assign run_o = new_write && code == CMD_RUN;
	assign load_o = new_write && code != CMD_RUN;
	assign load_cntr_o = new_write && code == CMD_LOAD_CNTR;
	assign load_jump_o = new_write && code == CMD_LOAD_JUMP;
	assign clear_err_o = new_write && code == CMD_CLEAR_ERR;
	assign write_inst_o = new_write && code == CMD_WRITE_INST;
	assign write_ac_o = new_write && code == CMD_WRITE_AC;

endmodule

// File: verilog/rw_jump_logic.sv
// loop counters with shadow reload values and jump targets
// a loop body closed by a jump runs counter value plus one times
module rw_jump_logic import rw_mgr_pkg::*; (
	input  logic afi_clk,
	input  logic afi_reset_n,
	input  logic soft_reset_i,
	input  loop_cnt_t cmd_data_i,
	input  logic [1:0] reg_sel_i,
	input  logic load_cntr_i,
	input  logic load_jump_i,
	input  logic jump_i,
	input  logic [1:0] jump_reg_i,
	output logic jump_taken_o,
	output loop_cnt_t jump_addr_o
);

	loop_cnt_t cntr_q [4];
	loop_cnt_t shadow_q [4];
	loop_cnt_t target_q [4];

	always_ff @(posedge afi_clk or negedge afi_reset_n) begin
		if (!afi_reset_n) begin
			for (int i = 0; i < 4; i++) begin
				cntr_q[i] <= '0;
				shadow_q[i] <= '0;
				target_q[i] <= '0;
			end
		end else if (soft_reset_i) begin
			for (int i = 0; i < 4; i++) begin
				cntr_q[i] <= '0;
				shadow_q[i] <= '0;
				target_q[i] <= '0;
			end
		end else begin
			if (load_cntr_i) begin
				cntr_q[reg_sel_i] <= cmd_data_i;
				shadow_q[reg_sel_i] <= cmd_data_i;
			end else if (jump_i) begin
				// an exhausted counter falls through and rearms for the next pass
				if (cntr_q[jump_reg_i] != '0)
					cntr_q[jump_reg_i] <= cntr_q[jump_reg_i] - 1'b1;
				else
					cntr_q[jump_reg_i] <= shadow_q[jump_reg_i];
			end
			if (load_jump_i)
				target_q[reg_sel_i] <= cmd_data_i;
		end
	end

	assign jump_taken_o = jump_i && cntr_q[jump_reg_i] != '0;
	assign jump_addr_o = target_q[jump_reg_i];

endmodule

// File: verilog/rw_sequencer.sv
// command state machine, program counter and instruction RAM
// the RAM is read at the next PC so the fetched word lines up with the PC
module rw_sequencer import rw_mgr_pkg::*; (
	input  logic afi_clk,
	input  logic afi_reset_n,
	input  logic run_i,
	input  logic load_i,
	input  logic load_cntr_i,
	input  logic load_jump_i,
	input  logic write_inst_i,
	input  cmd_addr_t cmd_addr_i,
	input  host_data_t cmd_data_i,
	input  logic soft_reset_i,
	input  logic write_pending_i,
	input  logic read_pending_i,
	output logic cmd_done_o,
	output logic running_o,
	output pc_t pc_o,
	output logic inst_read_o,
	output ac_addr_t ac_addr_o,
	output do_code_t do_code_o,
	output dm_code_t dm_code_o
);

	rw_state_e state_q;
	pc_t pc_q;
	pc_t next_pc;
	inst_word_t inst_ram [2**$bits(pc_t)];
	inst_word_t inst_q;
	logic jump_taken;
	loop_cnt_t jump_addr;

	rw_jump_logic u_jump_logic (
		.afi_clk      (afi_clk),
		.afi_reset_n  (afi_reset_n),
		.soft_reset_i (soft_reset_i),
		.cmd_data_i   (cmd_data_i[$bits(loop_cnt_t)-1:0]),
		.reg_sel_i    (cmd_addr_i[1:0]),
		.load_cntr_i  (load_cntr_i),
		.load_jump_i  (load_jump_i),
		.jump_i       (running_o && inst_q[INST_JUMP_BIT]),
		.jump_reg_i   (inst_q[INST_JREG_MSB:INST_JREG_LSB]),
		.jump_taken_o (jump_taken),
		.jump_addr_o  (jump_addr)
	);

	always_comb begin
		if (soft_reset_i)
			next_pc = '0;
		else if (state_q == RW_IDLE && run_i)
			next_pc = pc_t'(cmd_data_i);
		else if (!running_o)
			next_pc = pc_q;
		else if (jump_taken)
			next_pc = pc_t'(jump_addr);
		else if (inst_q[INST_RETURN_BIT])
			next_pc = pc_q;
		else
			next_pc = pc_q + 1'b1;
	end

	always_ff @(posedge afi_clk) begin
		if (write_inst_i)
			inst_ram[pc_t'(cmd_addr_i)] <= inst_word_t'(cmd_data_i);
		inst_q <= inst_ram[next_pc];
	end

	always_ff @(posedge afi_clk or negedge afi_reset_n) begin
		if (!afi_reset_n) begin
			state_q <= RW_IDLE;
			pc_q <= '0;
		end else begin
			pc_q <= next_pc;
			unique case (state_q)
				RW_IDLE: begin
					if (run_i)
						state_q <= RW_RUNNING;
					else if (read_pending_i)
						state_q <= RW_READING;
					else if (load_i)
						state_q <= RW_DONE;
				end
				RW_RUNNING: begin
					if (inst_q[INST_RETURN_BIT])
						state_q <= RW_DONE;
				end
				RW_READING: state_q <= RW_DONE;
				RW_DONE: begin
					// wait for the host to drop its strobe
					if (!write_pending_i && !read_pending_i)
						state_q <= RW_IDLE;
				end
			endcase
		end
	end

	assign cmd_done_o = state_q == RW_DONE;
	assign running_o = state_q == RW_RUNNING;
	assign pc_o = pc_q;
	assign inst_read_o = running_o && inst_q[INST_READ_BIT];
	assign ac_addr_o = inst_q[INST_AC_MSB:INST_AC_LSB];
	assign do_code_o = inst_q[INST_DO_MSB:INST_DO_LSB];
	assign dm_code_o = inst_q[INST_DM_MSB:INST_DM_LSB];

endmodule

// File: verilog/rw_ac_ram.sv
// address/command RAM with per-rank chip-select masking
// chip selects stay high in any cycle that does not issue an AC word
module rw_ac_ram import rw_mgr_pkg::*; #(
	parameter int AFI_RATIO = 2,
	parameter int MEM_CS_WIDTH = 2
) (
	input  logic afi_clk,
	input  logic afi_reset_n,
	input  logic write_ac_i,
	input  cmd_addr_t cmd_addr_i,
	input  host_data_t cmd_data_i,
	input  ac_addr_t ac_addr_i,
	input  logic issue_i,
	input  logic [MEM_CS_WIDTH-1:0] cs_mask_i,
	output logic [AC_BUS_WIDTH-1:0] ac_bus_o,
	output logic [AFI_RATIO*MEM_CS_WIDTH-1:0] ac_cs_n_o
);

	ac_word_t ac_ram [2**$bits(ac_addr_t)];
	ac_word_t ac_q;
	logic issue_q;

	always_ff @(posedge afi_clk) begin
		if (write_ac_i)
			ac_ram[ac_addr_t'(cmd_addr_i)] <= ac_word_t'(cmd_data_i);
		ac_q <= ac_ram[ac_addr_i];
	end

	always_ff @(posedge afi_clk or negedge afi_reset_n) begin
		if (!afi_reset_n)
			issue_q <= 1'b0;
		else
			issue_q <= issue_i;
	end

	always_comb begin
		for (int p = 0; p < AFI_RATIO; p++)
			for (int r = 0; r < MEM_CS_WIDTH; r++)
				ac_cs_n_o[p*MEM_CS_WIDTH + r] = !issue_q || ac_q[AC_CS_LSB + p] || cs_mask_i[r];
	end

	assign ac_bus_o = ac_q[AC_BUS_WIDTH-1:0];

endmodule

// File: verilog/rw_write_pattern.sv
// expands the do/dm codes of an instruction into full-rate write data
// and data mask, registered to line up with the AC word
module rw_write_pattern import rw_mgr_pkg::*; #(
	parameter int AFI_RATIO = 2,
	parameter int MEM_DQ_WIDTH = 8
) (
	input  logic afi_clk,
	input  logic afi_reset_n,
	input  do_code_t do_code_i,
	input  dm_code_t dm_code_i,
	output logic [2*AFI_RATIO*MEM_DQ_WIDTH-1:0] afi_wdata_o,
	output logic [2*AFI_RATIO*dm_per_beat(MEM_DQ_WIDTH)-1:0] afi_dm_o,
	output logic [2*AFI_RATIO*MEM_DQ_WIDTH-1:0] pattern_o
);

	localparam int BEATS = 2 * AFI_RATIO;
	localparam int DM_W = dm_per_beat(MEM_DQ_WIDTH);

	logic [BEATS*DM_W-1:0] mask;

	// beat b repeats code bit b mod 4 on every DQ and bit b mod 3 on every mask lane
	always_comb begin
		for (int b = 0; b < BEATS; b++) begin
			pattern_o[b*MEM_DQ_WIDTH +: MEM_DQ_WIDTH] = {MEM_DQ_WIDTH{do_code_i[b % 4]}};
			mask[b*DM_W +: DM_W] = {DM_W{dm_code_i[b % 3]}};
		end
	end

	always_ff @(posedge afi_clk or negedge afi_reset_n) begin
		if (!afi_reset_n) begin
			afi_wdata_o <= '0;
			afi_dm_o <= '0;
		end else begin
			afi_wdata_o <= pattern_o;
			afi_dm_o <= mask;
		end
	end

endmodule

// File: verilog/rw_check_status.sv
// queue of expected read patterns, read data comparison, sticky per-DQ
// error bits and the host readback mux
module rw_check_status import rw_mgr_pkg::*; #(
	parameter int AFI_RATIO = 2,
	parameter int MEM_DQ_WIDTH = 8,
	parameter int CHECK_DEPTH = 8
) (
	input  logic afi_clk,
	input  logic afi_reset_n,
	input  logic soft_reset_i,
	input  logic clear_err_i,
	input  logic push_i,
	input  logic [2*AFI_RATIO*MEM_DQ_WIDTH-1:0] pattern_i,
	input  logic [2*AFI_RATIO*MEM_DQ_WIDTH-1:0] afi_rdata_i,
	input  logic afi_rdata_valid_i,
	input  cmd_addr_t cmd_addr_i,
	input  pc_t pc_i,
	output host_data_t avl_readdata_o
);

	localparam int DATA_W = 2 * AFI_RATIO * MEM_DQ_WIDTH;
	localparam int PTR_W = (CHECK_DEPTH > 1) ? $clog2(CHECK_DEPTH) : 1;
	localparam int CNT_W = $clog2(CHECK_DEPTH + 1);

	logic [DATA_W-1:0] queue_q [CHECK_DEPTH];
	logic [DATA_W-1:0] rdata_q;
	logic [DATA_W-1:0] mismatch;
	logic [MEM_DQ_WIDTH-1:0] miss_dq;
	logic [MEM_DQ_WIDTH-1:0] err_q;
	logic [PTR_W-1:0] wr_ptr_q;
	logic [PTR_W-1:0] rd_ptr_q;
	logic [CNT_W-1:0] count_q;
	logic valid_q;
	logic do_push;
	logic do_pop;

	assign do_push = push_i && count_q != CNT_W'(CHECK_DEPTH);
	assign do_pop = valid_q && count_q != '0;

	always_ff @(posedge afi_clk) begin
		rdata_q <= afi_rdata_i;
		if (do_push)
			queue_q[wr_ptr_q] <= pattern_i;
	end

	// fold every beat onto the DQ it came from
	always_comb begin
		mismatch = rdata_q ^ queue_q[rd_ptr_q];
		miss_dq = '0;
		for (int b = 0; b < 2 * AFI_RATIO; b++)
			miss_dq = miss_dq | mismatch[b*MEM_DQ_WIDTH +: MEM_DQ_WIDTH];
	end

	always_ff @(posedge afi_clk or negedge afi_reset_n) begin
		if (!afi_reset_n) begin
			valid_q <= 1'b0;
			wr_ptr_q <= '0;
			rd_ptr_q <= '0;
			count_q <= '0;
			err_q <= '0;
		end else if (soft_reset_i) begin
			valid_q <= 1'b0;
			wr_ptr_q <= '0;
			rd_ptr_q <= '0;
			count_q <= '0;
			err_q <= '0;
		end else begin
			valid_q <= afi_rdata_valid_i;
			if (do_push)
				wr_ptr_q <= (wr_ptr_q == PTR_W'(CHECK_DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
			if (do_pop)
				rd_ptr_q <= (rd_ptr_q == PTR_W'(CHECK_DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
			if (do_push && !do_pop)
				count_q <= count_q + 1'b1;
			else if (do_pop && !do_push)
				count_q <= count_q - 1'b1;
			if (clear_err_i)
				err_q <= '0;
			else if (do_pop)
				err_q <= err_q | miss_dq;
		end
	end

	always_comb begin
		if (cmd_addr_i == cmd_addr_t'(0))
			avl_readdata_o = host_data_t'(err_q);
		else if (cmd_addr_i == cmd_addr_t'(1))
			avl_readdata_o = host_data_t'(pc_i);
		else
			avl_readdata_o = '0;
	end

endmodule

// File: verilog/rw_manager_top.sv
// read/write manager core: host command decoder, sequencer, AC RAM,
// write pattern generator and read checker
module rw_manager_top import rw_mgr_pkg::*; #(
	parameter int AFI_RATIO = 2,
	parameter int MEM_DQ_WIDTH = 8,
	parameter int MEM_CS_WIDTH = 2,
	parameter int CHECK_DEPTH = 8
) (
	input  logic afi_clk,
	input  logic afi_reset_n,
	input  logic cmd_write_i,
	input  logic cmd_read_i,
	input  cmd_addr_t avl_address_i,
	input  host_data_t avl_writedata_i,
	input  logic [2*AFI_RATIO*MEM_DQ_WIDTH-1:0] afi_rdata_i,
	input  logic afi_rdata_valid_i,
	output host_data_t avl_readdata_o,
	output logic cmd_done_o,
	output logic [AC_BUS_WIDTH-1:0] ac_bus_o,
	output logic [AFI_RATIO*MEM_CS_WIDTH-1:0] ac_cs_n_o,
	output logic [2*AFI_RATIO*MEM_DQ_WIDTH-1:0] afi_wdata_o,
	output logic [2*AFI_RATIO*dm_per_beat(MEM_DQ_WIDTH)-1:0] afi_dm_o
);

	cmd_addr_t cmd_addr;
	host_data_t cmd_data;
	logic write_pending, read_pending;
	logic run, load, load_cntr, load_jump, clear_err, write_inst, write_ac;
	logic [MEM_CS_WIDTH-1:0] cs_mask;
	logic soft_reset;
	logic running;
	pc_t pc;
	logic inst_read;
	ac_addr_t ac_addr;
	do_code_t do_code;
	dm_code_t dm_code;
	logic [2*AFI_RATIO*MEM_DQ_WIDTH-1:0] pattern;

	rw_cmd_decoder #(.MEM_CS_WIDTH(MEM_CS_WIDTH)) u_cmd_decoder (
		.afi_clk(afi_clk), .afi_reset_n(afi_reset_n),
		.cmd_write_i(cmd_write_i), .cmd_read_i(cmd_read_i),
		.avl_address_i(avl_address_i), .avl_writedata_i(avl_writedata_i),
		.cmd_addr_o(cmd_addr), .cmd_data_o(cmd_data),
		.write_pending_o(write_pending), .read_pending_o(read_pending),
		.run_o(run), .load_o(load), .load_cntr_o(load_cntr), .load_jump_o(load_jump),
		.clear_err_o(clear_err), .write_inst_o(write_inst), .write_ac_o(write_ac),
		.cs_mask_o(cs_mask), .soft_reset_o(soft_reset)
	);

	rw_sequencer u_sequencer (
		.afi_clk(afi_clk), .afi_reset_n(afi_reset_n),
		.run_i(run), .load_i(load), .load_cntr_i(load_cntr), .load_jump_i(load_jump),
		.write_inst_i(write_inst), .cmd_addr_i(cmd_addr), .cmd_data_i(cmd_data),
		.soft_reset_i(soft_reset),
		.write_pending_i(write_pending), .read_pending_i(read_pending),
		.cmd_done_o(cmd_done_o), .running_o(running), .pc_o(pc), .inst_read_o(inst_read),
		.ac_addr_o(ac_addr), .do_code_o(do_code), .dm_code_o(dm_code)
	);

	rw_ac_ram #(.AFI_RATIO(AFI_RATIO), .MEM_CS_WIDTH(MEM_CS_WIDTH)) u_ac_ram (
		.afi_clk(afi_clk), .afi_reset_n(afi_reset_n),
		.write_ac_i(write_ac), .cmd_addr_i(cmd_addr), .cmd_data_i(cmd_data),
		.ac_addr_i(ac_addr), .issue_i(running), .cs_mask_i(cs_mask),
		.ac_bus_o(ac_bus_o), .ac_cs_n_o(ac_cs_n_o)
	);

	rw_write_pattern #(.AFI_RATIO(AFI_RATIO), .MEM_DQ_WIDTH(MEM_DQ_WIDTH)) u_write_pattern (
		.afi_clk(afi_clk), .afi_reset_n(afi_reset_n),
		.do_code_i(do_code), .dm_code_i(dm_code),
		.afi_wdata_o(afi_wdata_o), .afi_dm_o(afi_dm_o), .pattern_o(pattern)
	);

	rw_check_status #(
		.AFI_RATIO(AFI_RATIO), .MEM_DQ_WIDTH(MEM_DQ_WIDTH), .CHECK_DEPTH(CHECK_DEPTH)
	) u_check_status (
		.afi_clk(afi_clk), .afi_reset_n(afi_reset_n),
		.soft_reset_i(soft_reset), .clear_err_i(clear_err),
		.push_i(inst_read), .pattern_i(pattern),
		.afi_rdata_i(afi_rdata_i), .afi_rdata_valid_i(afi_rdata_valid_i),
		.cmd_addr_i(cmd_addr), .pc_i(pc), .avl_readdata_o(avl_readdata_o)
	);

endmodule

// File: sim/tb_clock.sv
// testbench clock and power-on reset for the read/write manager
module tb_clock #(
	parameter int PERIOD = 20,
	parameter int RESET_CYCLES = 2
) (
	output logic afi_clk_o,
	output logic afi_reset_n_o
);

	initial begin
		afi_clk_o = 1'b0;
		forever #(PERIOD / 2) afi_clk_o = ~afi_clk_o;
	end

	initial begin
		afi_reset_n_o = 1'b0;
		repeat (RESET_CYCLES) @(posedge afi_clk_o);
		@(negedge afi_clk_o);
		afi_reset_n_o = 1'b1;
	end

endmodule

// File: sim/rw_manager_checker.sv
// concurrent checks on the command done handshake, the idle PC and the
// idle chip selects of the read/write manager
module rw_manager_checker import rw_mgr_pkg::*; #(
	parameter int CS_BITS = 4
) (
	input logic afi_clk,
	input logic afi_reset_n,
	input rw_state_e state,
	input logic cmd_done,
	input logic write_pending,
	input logic read_pending,
	input logic run,
	input logic soft_reset,
	input logic running,
	input pc_t pc,
	input logic [CS_BITS-1:0] cs_n
);

	// a finished command stays done until both registered strobes are low
	done_until_released: assert property (@(posedge afi_clk) disable iff (!afi_reset_n)
		cmd_done |=> cmd_done == ($past(write_pending) || $past(read_pending)))
		else $error("cmd_done_o did not follow the host strobes");

	// only a run or a soft reset may move the PC out of idle
	pc_stable_idle: assert property (@(posedge afi_clk) disable iff (!afi_reset_n)
		(state == RW_IDLE && !run && !soft_reset) |=> pc == $past(pc))
		else $error("PC changed while the sequencer was idle");

	cs_high_idle: assert property (@(posedge afi_clk) disable iff (!afi_reset_n)
		!running |=> &cs_n)
		else $error("chip select active outside a run");

endmodule

// File: sim/rw_manager_tb.sv
// directed tests for the read/write manager: host commands, program runs,
// loops, read checking, chip-select masking and soft reset
// includes the memory read reply model and the write cycle monitor
module rw_manager_tb;
	import rw_mgr_pkg::*;

	logic afi_clk;
	logic afi_reset_n;
	logic cmd_write_i;
	logic cmd_read_i;
	logic [11:0] avl_address_i;
	logic [31:0] avl_writedata_i;
	logic [31:0] afi_rdata_i;
	logic afi_rdata_valid_i;
	logic [31:0] avl_readdata_o;
	logic cmd_done_o;
	logic [23:0] ac_bus_o;
	logic [3:0] ac_cs_n_o;
	logic [31:0] afi_wdata_o;
	logic [3:0] afi_dm_o;

	int errors = 0;
	int checks = 0;
	int wr_count = 0;
	logic [31:0] exp_wdata[$];
	logic [3:0] exp_dm[$];
	logic [3:0] exp_cs[$];
	logic [23:0] exp_bus[$];
	int reply_code[$];
	int reply_flip[$];
	logic [2:0] due = '0;

	tb_clock #(.PERIOD(20), .RESET_CYCLES(2)) u_clock (
		.afi_clk_o(afi_clk), .afi_reset_n_o(afi_reset_n)
	);

	rw_manager_top i_dut (
		.afi_clk(afi_clk), .afi_reset_n(afi_reset_n),
		.cmd_write_i(cmd_write_i), .cmd_read_i(cmd_read_i),
		.avl_address_i(avl_address_i), .avl_writedata_i(avl_writedata_i),
		.afi_rdata_i(afi_rdata_i), .afi_rdata_valid_i(afi_rdata_valid_i),
		.avl_readdata_o(avl_readdata_o), .cmd_done_o(cmd_done_o),
		.ac_bus_o(ac_bus_o), .ac_cs_n_o(ac_cs_n_o),
		.afi_wdata_o(afi_wdata_o), .afi_dm_o(afi_dm_o)
	);

	bind rw_manager_top rw_manager_checker #(.CS_BITS(AFI_RATIO * MEM_CS_WIDTH)) u_checker (
		.afi_clk(afi_clk), .afi_reset_n(afi_reset_n),
		.state(u_sequencer.state_q), .cmd_done(cmd_done_o),
		.write_pending(write_pending), .read_pending(read_pending),
		.run(run), .soft_reset(soft_reset), .running(running),
		.pc(pc), .cs_n(ac_cs_n_o)
	);

	task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Error at %0t: %s is %h, expected %h", $time, name, got, exp);
		end
	endtask

	// every DQ of beat b carries code bit b mod 4
	function automatic logic [31:0] data_pattern(input logic [3:0] code);
		logic [31:0] d;
		for (int b = 0; b < 4; b++)
			d[b*8 +: 8] = {8{code[b % 4]}};
		return d;
	endfunction

	function automatic logic [3:0] mask_pattern(input logic [2:0] code);
		logic [3:0] m;
		for (int b = 0; b < 4; b++)
			m[b] = code[b % 3];
		return m;
	endfunction

	// cs_n bit p*2+r is the AC chip-select level of phase p or the rank mask
	function automatic logic [3:0] cs_levels(input logic [1:0] ac_cs, input logic [1:0] mask);
		logic [3:0] c;
		for (int p = 0; p < 2; p++)
			for (int r = 0; r < 2; r++)
				c[p*2 + r] = ac_cs[p] | mask[r];
		return c;
	endfunction

	function automatic logic [19:0] make_inst(input logic ret, input logic rd, input logic jmp,
		input logic [5:0] ac, input logic [3:0] code, input logic [2:0] dm);
		return {ret, rd, 2'b00, jmp, 2'b00, ac, code, dm};
	endfunction

	task automatic send_cmd(input logic wr, input logic [11:0] addr, input logic [31:0] data,
		input int limit, output logic [31:0] rdata);
		int n;
		@(negedge afi_clk);
		cmd_write_i = wr;
		cmd_read_i = !wr;
		avl_address_i = addr;
		avl_writedata_i = data;
		n = 0;
		while (!cmd_done_o && n < limit) begin
			@(negedge afi_clk);
			n++;
		end
		if (!cmd_done_o) begin
			errors++;
			$display("cmd_done_o never rose for command at address %h", addr);
		end
		rdata = avl_readdata_o;
		cmd_write_i = 1'b0;
		cmd_read_i = 1'b0;
		n = 0;
		while (cmd_done_o && n < limit) begin
			@(negedge afi_clk);
			n++;
		end
		if (cmd_done_o) begin
			errors++;
			$display("cmd_done_o stayed high after the strobe was dropped");
		end
	endtask

	task automatic write_cmd(input cmd_code_t code, input int idx, input logic [31:0] data);
		logic [31:0] unused;
		send_cmd(1'b1, {code, 8'(idx)}, data, 50, unused);
	endtask

	task automatic read_reg(input int addr, output logic [31:0] value);
		send_cmd(1'b0, 12'(addr), '0, 50, value);
	endtask

	task automatic run_prog(input int start);
		logic [31:0] unused;
		send_cmd(1'b1, {CMD_RUN, 8'd0}, 32'(start), 500, unused);
	endtask

	task automatic drain_replies();
		int n;
		n = 0;
		while ((reply_code.size() != 0 || due != 0) && n < 50) begin
			@(negedge afi_clk);
			n++;
		end
		if (reply_code.size() != 0) begin
			errors++;
			$display("expected read replies were never requested");
		end
		// registered reply plus the compare stage
		repeat (3) @(negedge afi_clk);
	endtask

	// write cycle monitor
	always @(negedge afi_clk) begin
		if (ac_bus_o[23] === 1'b1) begin
			wr_count++;
			if (exp_wdata.size() == 0) begin
				errors++;
				$display("unexpected write cycle at %0t", $time);
			end else begin
				check("ac_bus_o", 64'(ac_bus_o), 64'(exp_bus.pop_front()));
				check("afi_wdata_o", 64'(afi_wdata_o), 64'(exp_wdata.pop_front()));
				check("afi_dm_o", 64'(afi_dm_o), 64'(exp_dm.pop_front()));
				check("ac_cs_n_o", 64'(ac_cs_n_o), 64'(exp_cs.pop_front()));
			end
		end
	end

	// memory model answers each read-marked AC word three cycles later
	always @(negedge afi_clk) begin
		afi_rdata_valid_i = 1'b0;
		if (due[2]) begin
			if (reply_code.size() == 0) begin
				errors++;
				$display("read issued with no expected pattern queued");
			end else begin
				afi_rdata_i = data_pattern(4'(reply_code.pop_front()));
				if (reply_flip[0] >= 0)
					afi_rdata_i = afi_rdata_i ^ (32'd1 << reply_flip[0]);
				void'(reply_flip.pop_front());
				afi_rdata_valid_i = 1'b1;
			end
		end
		due = {due[1:0], ac_bus_o[22] === 1'b1};
	end

	task automatic reset_and_load();
		logic [31:0] v;
		check("cmd_done_o", 64'(cmd_done_o), 64'd0);
		check("ac_cs_n_o", 64'(ac_cs_n_o), 64'hf);
		read_reg(0, v);
		check("error word", 64'(v), 64'd0);
		read_reg(1, v);
		check("pc", 64'(v), 64'd0);
		write_cmd(CMD_SET_CS_MASK, 0, 32'd0);
		write_cmd(CMD_WRITE_AC, 0, 32'h0300_0000);
		write_cmd(CMD_WRITE_AC, 1, 32'h0080_1234);
		write_cmd(CMD_WRITE_AC, 2, 32'h0040_0056);
		write_cmd(CMD_WRITE_AC, 3, 32'h0280_0000);
		write_cmd(CMD_WRITE_INST, 0, 32'(make_inst(1, 0, 0, 0, 0, 0)));
	endtask

	task automatic write_program();
		logic [31:0] v;
		logic [3:0] code;
		logic [2:0] dm;
		for (int i = 0; i < 5; i++) begin
			code = 4'($urandom % 16);
			dm = 3'($urandom % 8);
			write_cmd(CMD_WRITE_INST, 8 + i, 32'(make_inst(0, 0, 0, 1, code, dm)));
			exp_bus.push_back(24'h80_1234);
			exp_wdata.push_back(data_pattern(code));
			exp_dm.push_back(mask_pattern(dm));
			exp_cs.push_back(cs_levels(2'b00, 2'b00));
		end
		write_cmd(CMD_WRITE_INST, 13, 32'(make_inst(1, 0, 0, 0, 0, 0)));
		run_prog(8);
		check("pending write cycles", 64'(exp_wdata.size()), 64'd0);
		read_reg(1, v);
		check("pc", 64'(v), 64'd13);
	endtask

	task automatic loop_program(input int n);
		logic [3:0] code;
		int start_count;
		code = 4'($urandom % 16);
		write_cmd(CMD_LOAD_CNTR, 0, 32'(n));
		write_cmd(CMD_LOAD_JUMP, 0, 32'd16);
		write_cmd(CMD_WRITE_INST, 16, 32'(make_inst(0, 0, 0, 1, code, 3'b101)));
		write_cmd(CMD_WRITE_INST, 17, 32'(make_inst(0, 0, 1, 0, 0, 0)));
		write_cmd(CMD_WRITE_INST, 18, 32'(make_inst(1, 0, 0, 0, 0, 0)));
		for (int i = 0; i <= n; i++) begin
			exp_bus.push_back(24'h80_1234);
			exp_wdata.push_back(data_pattern(code));
			exp_dm.push_back(mask_pattern(3'b101));
			exp_cs.push_back(cs_levels(2'b00, 2'b00));
		end
		start_count = wr_count;
		run_prog(16);
		check("loop write cycles", 64'(wr_count - start_count), 64'(n + 1));
	endtask

	task automatic read_compare();
		logic [31:0] v;
		int codes[3];
		int d;
		for (int i = 0; i < 3; i++) begin
			codes[i] = int'($urandom % 16);
			write_cmd(CMD_WRITE_INST, 32 + i, 32'(make_inst(0, 1, 0, 2, 4'(codes[i]), 0)));
		end
		write_cmd(CMD_WRITE_INST, 35, 32'(make_inst(1, 0, 0, 0, 0, 0)));
		for (int i = 0; i < 3; i++) begin
			reply_code.push_back(codes[i]);
			reply_flip.push_back(-1);
		end
		run_prog(32);
		drain_replies();
		read_reg(0, v);
		check("error word", 64'(v), 64'd0);
		d = int'($urandom % 8);
		for (int i = 0; i < 3; i++) begin
			reply_code.push_back(codes[i]);
			reply_flip.push_back(i == 1 ? 16 + d : -1);
		end
		run_prog(32);
		drain_replies();
		read_reg(0, v);
		check("error word", 64'(v), 64'd1 << d);
		write_cmd(CMD_CLEAR_ERR, 0, 32'd0);
		read_reg(0, v);
		check("error word", 64'(v), 64'd0);
	endtask

	task automatic cs_masking();
		write_cmd(CMD_SET_CS_MASK, 0, 32'b10);
		write_cmd(CMD_WRITE_INST, 48, 32'(make_inst(0, 0, 0, 3, 4'h5, 3'd2)));
		write_cmd(CMD_WRITE_INST, 49, 32'(make_inst(0, 0, 0, 1, 4'ha, 3'd4)));
		write_cmd(CMD_WRITE_INST, 50, 32'(make_inst(1, 0, 0, 0, 0, 0)));
		exp_bus.push_back(24'h80_0000);
		exp_wdata.push_back(data_pattern(4'h5));
		exp_dm.push_back(mask_pattern(3'd2));
		exp_cs.push_back(cs_levels(2'b10, 2'b10));
		exp_bus.push_back(24'h80_1234);
		exp_wdata.push_back(data_pattern(4'ha));
		exp_dm.push_back(mask_pattern(3'd4));
		exp_cs.push_back(cs_levels(2'b00, 2'b10));
		run_prog(48);
		check("pending write cycles", 64'(exp_wdata.size()), 64'd0);
		write_cmd(CMD_SET_CS_MASK, 0, 32'd0);
	endtask

	task automatic soft_reset_pc();
		logic [31:0] v;
		read_reg(1, v);
		check("pc", 64'(v), 64'd50);
		write_cmd(CMD_SOFT_RESET, 0, 32'd0);
		read_reg(1, v);
		check("pc", 64'(v), 64'd0);
	endtask

	initial begin
		int n;
		cmd_write_i = 1'b0;
		cmd_read_i = 1'b0;
		avl_address_i = '0;
		avl_writedata_i = '0;
		afi_rdata_i = '0;
		afi_rdata_valid_i = 1'b0;
		void'($urandom(20));
		n = 0;
		while (afi_reset_n !== 1'b1 && n < 20) begin
			@(negedge afi_clk);
			n++;
		end
		if (afi_reset_n !== 1'b1) begin
			errors++;
			$display("reset was never released");
		end
		@(negedge afi_clk);
		reset_and_load();
		write_program();
		loop_program(3);
		read_compare();
		cs_masking();
		soft_reset_pc();
		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0)
			$display("all tests passed");
		else
			$display("tests failed");
		$finish;
	end

	initial begin
		#1000000;
		$display("simulation timed out");
		$display("tests failed");
		$finish;
	end

endmodule

// File: files.f
verilog/rw_mgr_pkg.sv
verilog/rw_cmd_decoder.sv
verilog/rw_jump_logic.sv
verilog/rw_sequencer.sv
verilog/rw_ac_ram.sv
verilog/rw_write_pattern.sv
verilog/rw_check_status.sv
verilog/rw_manager_top.sv
sim/tb_clock.sv
sim/rw_manager_checker.sv
sim/rw_manager_tb.sv

// File: run.sh
#!/bin/bash
# build and run the read/write manager testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal -f files.f \
	--top-module rw_manager_tb -o rw_manager_sim \
	&& ./obj_dir/rw_manager_sim > sim.log 2>&1 \
	|| { cat sim.log 2>/dev/null; echo "build or simulation error"; exit 1; }
cat sim.log
grep -q "all tests passed" sim.log && exit 0 || exit 1
